/* riscvPkg.sv */
// Core widths, NOP encoding, funct3 codes, opcode and ALU enums, operand bypass function
package riscvPkg;

	// ==========================================================
	// Widths and constants
	// ==========================================================
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

	// funct3 values decode looks at
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SR  = 3'b101; // srl / sra

	// ==========================================================
	// Major opcodes in scope
	// ==========================================================
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	// ALU operation is {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SUB = 4'b1000,
		ALU_SLL = 4'b0001,
		ALU_SLT = 4'b0010,
		ALU_XOR = 4'b0100,
		ALU_SRL = 4'b0101,
		ALU_SRA = 4'b1101,
		ALU_OR  = 4'b0110,
		ALU_AND = 4'b0111
	} aluOp_e;

	// ==========================================================
	// Operand bypass
	// ==========================================================
	// Memory stage wins over writeback, x0 never bypassed
	function automatic logic [XLEN-1:0] fwdOperand(
		input logic [REG_ADDR_W-1:0] srcAddr,
		input logic [XLEN-1:0]       regVal,
		input logic [REG_ADDR_W-1:0] memRd,
		input logic                  memWe,
		input logic [XLEN-1:0]       memVal,
		input logic [REG_ADDR_W-1:0] wbRd,
		input logic                  wbWe,
		input logic [XLEN-1:0]       wbVal
	);
		logic [XLEN-1:0] result;
		if (srcAddr == '0) begin
			result = regVal;
		end else if (memWe && (memRd == srcAddr)) begin
			result = memVal;
		end else if (wbWe && (wbRd == srcAddr)) begin
			result = wbVal;
		end else begin
			result = regVal;
		end
		return result;
	endfunction

endpackage

/* regFile.sv */
// Integer register file with x0 held at zero and same-cycle write bypass
module regFile
	import riscvPkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs1Addr,
	input  logic [REG_ADDR_W-1:0] rs2Addr,
	input  logic [REG_ADDR_W-1:0] rdAddr,
	input  logic                  rdWrite,
	input  logic [XLEN-1:0]       rdData,
	output logic [XLEN-1:0]       rs1Data,
	output logic [XLEN-1:0]       rs2Data
);
	logic [XLEN-1:0] regs [0:NUM_REGS-1];
	logic            wrValid;

	assign wrValid = rdWrite && (rdAddr != '0); // x0 is never written

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrValid) begin
			regs[rdAddr] <= rdData;
		end
	end

	// Writeback lands on the read ports in the same cycle
	assign rs1Data = (wrValid && (rdAddr == rs1Addr)) ? rdData : regs[rs1Addr];
	assign rs2Data = (wrValid && (rdAddr == rs2Addr)) ? rdData : regs[rs2Addr];

endmodule

/* fetchDecode.sv */
// PC, IF/ID register, control decode, immediates, branch resolve and hazard stall
module fetchDecode
	import riscvPkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  freeze,
	input  logic [XLEN-1:0]       instRdata,
	output logic                  instRead,
	output logic [XLEN-3:0]       instAddr,
	output logic [REG_ADDR_W-1:0] rs1Addr,
	output logic [REG_ADDR_W-1:0] rs2Addr,
	input  logic [XLEN-1:0]       rs1Data,
	input  logic [XLEN-1:0]       rs2Data,
	input  logic [REG_ADDR_W-1:0] memRdAddr,
	input  logic                  memRegWrite,
	input  logic [XLEN-1:0]       memAluResult,
	input  logic [REG_ADDR_W-1:0] wbRdAddr,
	input  logic                  wbRegWrite,
	input  logic [XLEN-1:0]       wbData,
	input  logic [REG_ADDR_W-1:0] exRdAddr,
	input  logic                  exRegWrite,
	input  logic                  exMemRead,
	output aluOp_e                idAluOp,
	output logic                  idAluSrc,
	output logic                  idMemRead,
	output logic                  idMemWrite,
	output logic                  idMemToReg,
	output logic                  idRegWrite,
	output logic                  idIsLink,
	output logic [REG_ADDR_W-1:0] idRs1Addr,
	output logic [REG_ADDR_W-1:0] idRs2Addr,
	output logic [REG_ADDR_W-1:0] idRdAddr,
	output logic [XLEN-1:0]       idRs1Data,
	output logic [XLEN-1:0]       idRs2Data,
	output logic [XLEN-1:0]       idImm,
	output logic [XLEN-1:0]       idPcPlus4
);
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] ifIdPc;
	logic [XLEN-1:0] ifIdInst;
	logic            memLoadQ; // load sitting in the memory stage
	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            aluSrc, memRead, memWrite, memToReg, regWrite, isLink, isBranch;
	logic            useRs1, useRs2;
	logic [XLEN-1:0] brA, brB;
	logic            taken, hazardStall, loadUse, branchEx, branchMem;

	// ==========================================================
	// Fetch
	// ==========================================================
	assign instRead = 1'b1; // always fetching, held by freeze
	assign instAddr = pc[XLEN-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= '0;
			ifIdPc   <= '0;
			ifIdInst <= NOP_INST;
		end else if (!freeze && !hazardStall) begin
			pc       <= taken ? (ifIdPc + idImm) : (pc + XLEN'(4));
			ifIdPc   <= pc;
			ifIdInst <= taken ? NOP_INST : instRdata; // kill the wrong-path fetch
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memLoadQ <= 1'b0;
		end else if (!freeze) begin
			memLoadQ <= exMemRead;
		end
	end

	// ==========================================================
	// Decode
	// ==========================================================
	assign opcode = opcode_e'(ifIdInst[6:0]);
	assign funct3 = ifIdInst[14:12];

	always_comb begin
		idAluOp = ALU_ADD;
		{aluSrc, memRead, memWrite, memToReg, regWrite, isLink, isBranch} = '0;
		{useRs1, useRs2} = 2'b00;
		idImm = '0;
		case (opcode)
			OP_REG: begin
				idAluOp = aluOp_e'({ifIdInst[30], funct3});
				{regWrite, useRs1, useRs2} = 3'b111;
			end
			OP_IMM: begin
				// Only shifts-right carry funct7[5] into the op
				idAluOp = aluOp_e'({(funct3 == F3_SR) & ifIdInst[30], funct3});
				{aluSrc, regWrite, useRs1} = 3'b111;
				if ((funct3 == F3_SLL) || (funct3 == F3_SR))
					idImm = {{(XLEN-5){1'b0}}, ifIdInst[24:20]}; // shamt
				else
					idImm = {{(XLEN-12){ifIdInst[31]}}, ifIdInst[31:20]};
			end
			OP_LOAD: begin
				{aluSrc, memRead, memToReg, regWrite, useRs1} = 5'b11111;
				idImm = {{(XLEN-12){ifIdInst[31]}}, ifIdInst[31:20]};
			end
			OP_STORE: begin
				{aluSrc, memWrite, useRs1, useRs2} = 4'b1111;
				idImm = {{(XLEN-12){ifIdInst[31]}}, ifIdInst[31:25], ifIdInst[11:7]};
			end
			OP_BRANCH: begin
				isBranch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
				{useRs1, useRs2} = 2'b11;
				idImm = {{(XLEN-13){ifIdInst[31]}}, ifIdInst[31], ifIdInst[7],
					ifIdInst[30:25], ifIdInst[11:8], 1'b0};
			end
			OP_JAL: begin
				{regWrite, isLink} = 2'b11;
				idImm = {{(XLEN-21){ifIdInst[31]}}, ifIdInst[31], ifIdInst[19:12],
					ifIdInst[20], ifIdInst[30:21], 1'b0};
			end
			default: ; // unknown opcode decodes as a bubble
		endcase
	end

	assign rs1Addr = useRs1 ? ifIdInst[19:15] : '0;
	assign rs2Addr = useRs2 ? ifIdInst[24:20] : '0;

	// ==========================================================
	// Branch resolve and hazards
	// ==========================================================
	assign brA = fwdOperand(rs1Addr, rs1Data, memRdAddr, memRegWrite, memAluResult,
		wbRdAddr, wbRegWrite, wbData);
	assign brB = fwdOperand(rs2Addr, rs2Data, memRdAddr, memRegWrite, memAluResult,
		wbRdAddr, wbRegWrite, wbData);

	assign loadUse   = exMemRead && (exRdAddr != '0) &&
		((exRdAddr == rs1Addr) || (exRdAddr == rs2Addr));
	assign branchEx  = isBranch && exRegWrite && (exRdAddr != '0) &&
		((exRdAddr == rs1Addr) || (exRdAddr == rs2Addr));
	assign branchMem = isBranch && memLoadQ && (memRdAddr != '0) &&
		((memRdAddr == rs1Addr) || (memRdAddr == rs2Addr)); // load data not back yet
	assign hazardStall = loadUse || branchEx || branchMem;

	assign taken = !hazardStall &&
		(isLink || (isBranch && ((brA == brB) ^ (funct3 == F3_BNE))));

	// Bubble into execute while stalled
	assign idAluSrc   = aluSrc;
	assign idMemRead  = memRead && !hazardStall;
	assign idMemWrite = memWrite && !hazardStall;
	assign idMemToReg = memToReg && !hazardStall;
	assign idRegWrite = regWrite && !hazardStall;
	assign idIsLink   = isLink && !hazardStall;
	assign idRs1Addr  = rs1Addr;
	assign idRs2Addr  = rs2Addr;
	assign idRdAddr   = ifIdInst[11:7];
	assign idRs1Data  = rs1Data;
	assign idRs2Data  = rs2Data;
	assign idPcPlus4  = ifIdPc + XLEN'(4);

endmodule

/* executeStage.sv */
// ID/EX register, operand bypass muxes and ALU
module executeStage
	import riscvPkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  freeze,
	input  aluOp_e                idAluOp,
	input  logic                  idAluSrc,
	input  logic                  idMemRead,
	input  logic                  idMemWrite,
	input  logic                  idMemToReg,
	input  logic                  idRegWrite,
	input  logic                  idIsLink,
	input  logic [REG_ADDR_W-1:0] idRs1Addr,
	input  logic [REG_ADDR_W-1:0] idRs2Addr,
	input  logic [REG_ADDR_W-1:0] idRdAddr,
	input  logic [XLEN-1:0]       idRs1Data,
	input  logic [XLEN-1:0]       idRs2Data,
	input  logic [XLEN-1:0]       idImm,
	input  logic [XLEN-1:0]       idPcPlus4,
	input  logic [REG_ADDR_W-1:0] memRdAddr,
	input  logic                  memRegWrite,
	input  logic [XLEN-1:0]       memAluResult,
	input  logic [REG_ADDR_W-1:0] wbRdAddr,
	input  logic                  wbRegWrite,
	input  logic [XLEN-1:0]       wbData,
	output logic [REG_ADDR_W-1:0] exRdAddr,
	output logic                  exRegWrite,
	output logic                  exMemRead,
	output logic                  exMemWrite,
	output logic                  exMemToReg,
	output logic                  exIsLink,
	output logic [XLEN-1:0]       exAluResult,
	output logic [XLEN-1:0]       exStoreData,
	output logic [XLEN-1:0]       exPcPlus4
);
	aluOp_e                aluOp;
	logic                  aluSrc;
	logic [REG_ADDR_W-1:0] rs1Addr;
	logic [REG_ADDR_W-1:0] rs2Addr;
	logic [XLEN-1:0]       rs1Q;
	logic [XLEN-1:0]       rs2Q;
	logic [XLEN-1:0]       immQ;
	logic [XLEN-1:0]       opA;
	logic [XLEN-1:0]       opB;
	logic [4:0]            shamt;

	// ==========================================================
	// ID/EX register
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			aluOp      <= ALU_ADD;
			aluSrc     <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exRegWrite <= 1'b0;
			exIsLink   <= 1'b0;
			rs1Addr    <= '0;
			rs2Addr    <= '0;
			exRdAddr   <= '0;
		end else if (!freeze) begin
			aluOp      <= idAluOp;
			aluSrc     <= idAluSrc;
			exMemRead  <= idMemRead;
			exMemWrite <= idMemWrite;
			exMemToReg <= idMemToReg;
			exRegWrite <= idRegWrite;
			exIsLink   <= idIsLink;
			rs1Addr    <= idRs1Addr;
			rs2Addr    <= idRs2Addr;
			exRdAddr   <= idRdAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			rs1Q      <= idRs1Data;
			rs2Q      <= idRs2Data;
			immQ      <= idImm;
			exPcPlus4 <= idPcPlus4;
		end
	end

	// Operand select
	assign opA = fwdOperand(rs1Addr, rs1Q, memRdAddr, memRegWrite, memAluResult,
		wbRdAddr, wbRegWrite, wbData);
	assign exStoreData = fwdOperand(rs2Addr, rs2Q, memRdAddr, memRegWrite, memAluResult,
		wbRdAddr, wbRegWrite, wbData);
	assign opB   = aluSrc ? immQ : exStoreData;
	assign shamt = opB[4:0];

	// ==========================================================
	// ALU
	// ==========================================================
	always_comb begin
		case (aluOp)
			ALU_ADD: exAluResult = opA + opB;
			ALU_SUB: exAluResult = opA - opB;
			ALU_SLL: exAluResult = opA << shamt;
			ALU_SLT: exAluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			ALU_XOR: exAluResult = opA ^ opB;
			ALU_SRL: exAluResult = opA >> shamt;
			ALU_SRA: exAluResult = $signed(opA) >>> shamt; // sign fill
			ALU_OR:  exAluResult = opA | opB;
			ALU_AND: exAluResult = opA & opB;
			default: exAluResult = '0;
		endcase
	end

endmodule

/* resultStage.sv */
// EX/MEM and MEM/WB registers, data port, writeback select and pipeline freeze
module resultStage
	import riscvPkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instStall,
	input  logic                  dataStall,
	input  logic [XLEN-1:0]       dataRdata,
	input  logic [REG_ADDR_W-1:0] exRdAddr,
	input  logic                  exRegWrite,
	input  logic                  exMemRead,
	input  logic                  exMemWrite,
	input  logic                  exMemToReg,
	input  logic                  exIsLink,
	input  logic [XLEN-1:0]       exAluResult,
	input  logic [XLEN-1:0]       exStoreData,
	input  logic [XLEN-1:0]       exPcPlus4,
	output logic                  freeze,
	output logic                  dataRead,
	output logic                  dataWrite,
	output logic [XLEN-3:0]       dataAddr,
	output logic [XLEN-1:0]       dataWdata,
	output logic [REG_ADDR_W-1:0] memRdAddr,
	output logic                  memRegWrite,
	output logic [XLEN-1:0]       memAluResult,
	output logic [REG_ADDR_W-1:0] wbRdAddr,
	output logic                  wbRegWrite,
	output logic [XLEN-1:0]       wbData
);
	logic            memReadQ, memWriteQ, memToRegQ, memIsLinkQ;
	logic [XLEN-1:0] aluQ, storeQ, memPcPlus4Q;
	logic            wbMemToRegQ, wbIsLinkQ;
	logic [XLEN-1:0] wbAluQ, wbLoadQ, wbPcPlus4Q;
	logic            dataDoneQ; // access finished while the other port stalls
	logic [XLEN-1:0] loadHoldQ;
	logic [XLEN-1:0] loadData;

	assign freeze = instStall || dataStall;

	// ==========================================================
	// EX/MEM and data port
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{memReadQ, memWriteQ, memToRegQ, memIsLinkQ, memRegWrite} <= '0;
			memRdAddr <= '0;
		end else if (!freeze) begin
			{memReadQ, memWriteQ, memToRegQ} <= {exMemRead, exMemWrite, exMemToReg};
			{memIsLinkQ, memRegWrite}        <= {exIsLink, exRegWrite};
			memRdAddr <= exRdAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			aluQ        <= exAluResult;
			storeQ      <= exStoreData;
			memPcPlus4Q <= exPcPlus4;
		end
	end

	// Keep a finished access from being issued twice
	always_ff @(posedge clk) begin
		if (!rst_n || !freeze) begin
			dataDoneQ <= 1'b0;
		end else if ((memReadQ || memWriteQ) && !dataStall) begin
			dataDoneQ <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (freeze && memReadQ && !dataStall && !dataDoneQ) begin
			loadHoldQ <= dataRdata;
		end
	end

	assign dataRead     = memReadQ && !dataDoneQ;
	assign dataWrite    = memWriteQ && !dataDoneQ;
	assign dataAddr     = aluQ[XLEN-1:2];
	assign dataWdata    = storeQ;
	assign memAluResult = memIsLinkQ ? memPcPlus4Q : aluQ; // jal forwards its link
	assign loadData     = dataDoneQ ? loadHoldQ : dataRdata;

	// ==========================================================
	// MEM/WB and writeback select
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{wbMemToRegQ, wbIsLinkQ, wbRegWrite} <= '0;
			wbRdAddr <= '0;
		end else if (!freeze) begin
			{wbMemToRegQ, wbIsLinkQ, wbRegWrite} <= {memToRegQ, memIsLinkQ, memRegWrite};
			wbRdAddr <= memRdAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wbAluQ     <= aluQ;
			wbLoadQ    <= loadData;
			wbPcPlus4Q <= memPcPlus4Q;
		end
	end

	assign wbData = wbIsLinkQ ? wbPcPlus4Q : (wbMemToRegQ ? wbLoadQ : wbAluQ);

endmodule

/* riscvCore.sv */
// Top level wiring of the pipeline stages and register file to both memory ports
module riscvCore
	import riscvPkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	output logic              instRead,
	output logic [XLEN-3:0]   instAddr,
	input  logic [XLEN-1:0]   instRdata,
	input  logic              instStall,
	output logic              dataRead,
	output logic              dataWrite,
	output logic [XLEN-3:0]   dataAddr,
	output logic [XLEN-1:0]   dataWdata,
	input  logic [XLEN-1:0]   dataRdata,
	input  logic              dataStall
);
	logic                  freeze;
	logic [REG_ADDR_W-1:0] rs1Addr, rs2Addr;
	logic [XLEN-1:0]       rs1Data, rs2Data;

	// Decode to execute
	aluOp_e                idAluOp;
	logic                  idAluSrc, idMemRead, idMemWrite, idMemToReg, idRegWrite, idIsLink;
	logic [REG_ADDR_W-1:0] idRs1Addr, idRs2Addr, idRdAddr;
	logic [XLEN-1:0]       idRs1Data, idRs2Data, idImm, idPcPlus4;

	// Execute to memory
	logic [REG_ADDR_W-1:0] exRdAddr;
	logic                  exRegWrite, exMemRead, exMemWrite, exMemToReg, exIsLink;
	logic [XLEN-1:0]       exAluResult, exStoreData, exPcPlus4;

	// Bypass sources from the back end
	logic [REG_ADDR_W-1:0] memRdAddr, wbRdAddr;
	logic                  memRegWrite, wbRegWrite;
	logic [XLEN-1:0]       memAluResult, wbData;

	fetchDecode  uFetchDecode (.*);
	executeStage uExecute     (.*);
	resultStage  uResult      (.*);

	regFile uRegFile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1Addr (rs1Addr),
		.rs2Addr (rs2Addr),
		.rdAddr  (wbRdAddr),
		.rdWrite (wbRegWrite),
		.rdData  (wbData),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

endmodule

/* riscvCore_asserts.sv */
// Bound protocol checks on the instruction and data ports of the core
module riscvCoreAsserts
	import riscvPkg::*;
(
	input logic            clk,
	input logic            rst_n,
	input logic            instRead,
	input logic [XLEN-3:0] instAddr,
	input logic            instStall,
	input logic            dataRead,
	input logic            dataWrite,
	input logic [XLEN-3:0] dataAddr,
	input logic [XLEN-1:0] dataWdata,
	input logic            dataStall
);
	int failCount; // read by the testbench

	initial failCount = 0;

	// ==========================================================
	// Data port
	// ==========================================================
	dataExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dataRead && dataWrite))
	else begin
		$error("data port read and write high in the same cycle");
		failCount++;
	end

	// Request frozen until the stall drops
	dataHeld: assert property (@(posedge clk) disable iff (!rst_n)
		((dataRead || dataWrite) && dataStall) |=>
			($stable(dataRead) && $stable(dataWrite) && $stable(dataAddr) && $stable(dataWdata)))
	else begin
		$error("data request changed while dataStall was high");
		failCount++;
	end

	// ==========================================================
	// Instruction port
	// ==========================================================
	instHeld: assert property (@(posedge clk) disable iff (!rst_n)
		(instRead && instStall) |=> $stable(instAddr))
	else begin
		$error("instAddr changed while instStall was high");
		failCount++;
	end

	fetchActive: assert property (@(posedge clk) disable iff (!rst_n) instRead)
	else begin
		$error("instRead low outside reset");
		failCount++;
	end

endmodule

/* tbRiscvCore.sv */
// Testbench for the pipelined core with program table, memory models, stalls and store checks
module tbRiscvCore
	import riscvPkg::*;
();
	localparam int PROG_DEPTH      = 64;
	localparam int PROG_LEN        = 43;
	localparam int DATA_DEPTH      = 64;
	localparam int NUM_STORES      = 14;
	localparam int STALL_ALLOWANCE = 400;
	localparam int CYCLE_LIMIT     = 20 * PROG_LEN + STALL_ALLOWANCE;
	localparam int DRAIN_CYCLES    = 20;
	localparam int DRIVE_DLY       = 1;
	localparam logic [31:0] RNG_SEED = 32'd98684;

	// Word address in the upper half, store data in the lower half
	localparam logic [63:0] STORE_TABLE [NUM_STORES] = '{
		{32'd0,  32'hFFFF_FFEF}, // add of negative and positive
		{32'd1,  32'h0000_0017}, // sub
		{32'd2,  32'h0000_0018}, // sll
		{32'd3,  32'h0000_0001}, // signed slt
		{32'd4,  32'hFFFF_FFEF}, // xor
		{32'd5,  32'h1FFF_FFFD}, // srl
		{32'd6,  32'hFFFF_FFFD}, // sra of a negative value
		{32'd7,  32'hFFFF_FFEF}, // or
		{32'd8,  32'h0000_0000}, // and
		{32'd9,  32'h0000_002B}, // srai and slli back to back
		{32'd10, 32'h0000_0018}, // load then immediate use
		{32'd11, 32'h0000_0003}, // bne fall-through
		{32'd12, 32'h0000_008C}, // jal link
		{32'd14, 32'hFFFF_FFEF}  // beq right after a load
	};

	logic            clk;
	logic            rst_n;
	logic            instRead;
	logic [XLEN-3:0] instAddr;
	logic [XLEN-1:0] instRdata;
	logic            instStall;
	logic            dataRead;
	logic            dataWrite;
	logic [XLEN-3:0] dataAddr;
	logic [XLEN-1:0] dataWdata;
	logic [XLEN-1:0] dataRdata;
	logic            dataStall;

	logic [XLEN-1:0] progMem [PROG_DEPTH];
	logic [XLEN-1:0] dataMem [DATA_DEPTH];
	logic [31:0]     rngState;
	logic            stallsOn;
	int              cycleCount;

	riscvCore dut (.*);

	bind riscvCore riscvCoreAsserts uChecks (.*);

	always #5 clk = ~clk;

	// ==========================================================
	// Memory models
	// ==========================================================
	assign instRdata = (instAddr < PROG_DEPTH) ? progMem[instAddr[5:0]] : NOP_INST;
	assign dataRdata = (dataAddr < DATA_DEPTH) ? dataMem[dataAddr[5:0]] : '0;

	always @(posedge clk) begin
		if (dataWrite && !dataStall && (dataAddr < DATA_DEPTH))
			dataMem[dataAddr[5:0]] <= dataWdata; // write lands on completion
	end

	// Random back-pressure on both ports
	always @(posedge clk) begin
		#DRIVE_DLY;
		if (stallsOn) begin
			rngState = nextRandom(rngState);
			instStall = (rngState[1:0] == 2'b00);
			dataStall = (rngState[5:4] == 2'b00);
		end else begin
			instStall = 1'b0;
			dataStall = 1'b0;
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ==========================================================
	// Instruction encoders
	// ==========================================================
	function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] iTypeWord(input opcode_e op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] branchWord(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < PROG_DEPTH; i++) begin
			progMem[i] = NOP_INST;
		end
		progMem[0]  = iTypeWord(OP_IMM, 3'b000, 1, 0, -20);     // x1 = -20
		progMem[1]  = iTypeWord(OP_IMM, 3'b000, 2, 0, 3);       // x2 = 3
		progMem[2]  = rTypeWord(7'h00, 3'b000, 3, 1, 2);        // add
		progMem[3]  = storeWord(3, 0, 0);
		progMem[4]  = rTypeWord(7'h20, 3'b000, 4, 2, 1);        // sub
		progMem[5]  = storeWord(4, 0, 4);
		progMem[6]  = rTypeWord(7'h00, 3'b001, 5, 2, 2);        // sll
		progMem[7]  = rTypeWord(7'h00, 3'b010, 6, 1, 2);        // slt
		progMem[8]  = storeWord(5, 0, 8);
		progMem[9]  = storeWord(6, 0, 12);
		progMem[10] = rTypeWord(7'h00, 3'b100, 7, 1, 2);        // xor
		progMem[11] = rTypeWord(7'h00, 3'b101, 8, 1, 2);        // srl
		progMem[12] = rTypeWord(7'h20, 3'b101, 9, 1, 2);        // sra
		progMem[13] = rTypeWord(7'h00, 3'b110, 10, 1, 2);       // or
		progMem[14] = rTypeWord(7'h00, 3'b111, 11, 1, 2);       // and
		progMem[15] = storeWord(7, 0, 16);
		progMem[16] = storeWord(8, 0, 20);
		progMem[17] = storeWord(9, 0, 24);
		progMem[18] = storeWord(10, 0, 28);
		progMem[19] = storeWord(11, 0, 32);
		progMem[20] = iTypeWord(OP_IMM, 3'b101, 12, 1, 12'h402); // srai by 2
		progMem[21] = iTypeWord(OP_IMM, 3'b001, 13, 2, 4);      // slli by 4
		progMem[22] = rTypeWord(7'h00, 3'b000, 14, 12, 13);
		progMem[23] = storeWord(14, 0, 36);
		progMem[24] = iTypeWord(OP_LOAD, 3'b010, 15, 0, 4);     // lw x15, 4(x0)
		progMem[25] = iTypeWord(OP_IMM, 3'b000, 16, 15, 1);     // load-use
		progMem[26] = storeWord(16, 0, 40);
		progMem[27] = branchWord(3'b000, 16, 5, 8);             // beq taken
		progMem[28] = storeWord(1, 0, 44);                      // skipped
		progMem[29] = branchWord(3'b001, 16, 5, 8);             // bne not taken
		progMem[30] = storeWord(2, 0, 44);
		progMem[31] = branchWord(3'b001, 1, 2, 8);              // bne taken
		progMem[32] = storeWord(1, 0, 48);                      // skipped
		progMem[33] = branchWord(3'b000, 1, 2, 8);              // beq not taken
		progMem[34] = jalWord(17, 12);
		progMem[35] = storeWord(1, 0, 48);                      // skipped
		progMem[36] = storeWord(1, 0, 52);                      // skipped
		progMem[37] = storeWord(17, 0, 48);                     // link value
		progMem[38] = iTypeWord(OP_LOAD, 3'b010, 18, 0, 0);
		progMem[39] = branchWord(3'b000, 18, 3, 8);             // two-cycle stall, taken
		progMem[40] = storeWord(1, 0, 56);                      // skipped
		progMem[41] = storeWord(18, 0, 56);
		progMem[42] = jalWord(0, 0);                            // park here
	endtask

	task automatic fillDataMemory();
		for (int i = 0; i < DATA_DEPTH; i++) begin
			dataMem[i] = 32'hA5A5_0000 ^ (i * 32'h0001_0001);
		end
	endtask

	// ==========================================================
	// Checking
	// ==========================================================
	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	// Returns in the cycle where a write completes
	task automatic waitForStore(input logic firstStore);
		do begin
			@(posedge clk);
			cycleCount++;
			assert (cycleCount < CYCLE_LIMIT)
				else reportFailure("timeout: no completed store within the cycle limit");
			assert (dut.uChecks.failCount == 0)
				else reportFailure("a bound port protocol assertion failed");
			if (firstStore) begin
				assert (!dataRead)
					else reportFailure("data read issued before the first store");
			end
		end while (!(dataWrite && !dataStall));
	endtask

	task automatic runProgram(input logic withStalls);
		@(negedge clk);
		stallsOn = withStalls;
		@(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b0;
		cycleCount = 0;
		fillDataMemory();
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		assert (instAddr == '0)
			else reportFailure($sformatf("error: instAddr 0x%h, expected 0x%h", instAddr, 30'h0));

		for (int i = 0; i < NUM_STORES; i++) begin
			waitForStore(i == 0);
			assert (XLEN'(dataAddr) == STORE_TABLE[i][63:32])
				else reportFailure($sformatf("error: dataAddr 0x%h, expected 0x%h",
					XLEN'(dataAddr), STORE_TABLE[i][63:32]));
			assert (dataWdata == STORE_TABLE[i][31:0])
				else reportFailure($sformatf("error: dataWdata 0x%h, expected 0x%h",
					dataWdata, STORE_TABLE[i][31:0]));
		end

		// Nothing may follow the last store
		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			assert (!(dataWrite || dataRead))
				else reportFailure("data access after the last expected store");
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		instStall = 1'b0;
		dataStall = 1'b0;
		stallsOn  = 1'b0;
		rngState  = RNG_SEED;
		loadProgram();
		fillDataMemory();

		runProgram(1'b0); // stall-free pass
		runProgram(1'b1); // same program under back-pressure

		if (dut.uChecks.failCount == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			reportFailure("a bound port protocol assertion failed");
		end
	end

endmodule

/* verilog.f */
riscvPkg.sv
regFile.sv
fetchDecode.sv
executeStage.sv
resultStage.sv
riscvCore.sv
riscvCore_asserts.sv
tbRiscvCore.sv

/* Bender.yml */
package:
  name: riscv_core

sources:
  - riscvPkg.sv
  - regFile.sv
  - fetchDecode.sv
  - executeStage.sv
  - resultStage.sv
  - riscvCore.sv
  - target: test
    files:
      - riscvCore_asserts.sv
      - tbRiscvCore.sv
